/* files.f */
hw/fog_pkg.sv
hw/fog_mod_gen.sv
hw/fog_err_demod.sv
hw/fog_feedback.sv
hw/fog_timebase.sv
hw/iris_top.sv
verif/tb_iris.sv

/* hw/fog_err_demod.sv */
`timescale 1ns/1ps

module fog_err_demod (
	input  logic                i_clk,
	input  logic                i_reset,
	input  fog_pkg::adc_t       i_adc,         // signed sample, one per clock
	input  fog_pkg::mod_phase_t i_phase,       // which sum the sample goes to
	input  fog_pkg::cnt_t       i_half_idx,    // position in the half period
	input  logic                i_period_stb,  // close the period this cycle
	input  fog_pkg::cnt_t       i_wait_cnt,    // settling cycles skipped per half
	input  logic                i_polarity,    // 1 flips the error sign
	input  fog_pkg::word_t      i_err_offset,
	output fog_pkg::word_t      o_err,
	output logic                o_err_stb
);
	import fog_pkg::*;

	word_t adc_ext;    // sample at loop width
	logic  sample_en;  // past the settling wait
	word_t sum_h;      // high half accumulator
	word_t sum_l;      // low half accumulator
	word_t sum_h_nxt;
	word_t sum_l_nxt;
	word_t diff;       // high minus low incl. this cycle
	word_t err_nxt;

	assign adc_ext   = word_t'(i_adc);  // sign extension from 14 bits
	assign sample_en = (i_half_idx >= i_wait_cnt);

	// current sample lands in one of the two sums
	always_comb begin
		sum_h_nxt = sum_h;
		sum_l_nxt = sum_l;
		if (sample_en) begin
			if (i_phase == MOD_HIGH) begin
				sum_h_nxt = sum_h + adc_ext;
			end else begin
				sum_l_nxt = sum_l + adc_ext;
			end
		end
	end

	// the period_stb cycle itself is still a sample cycle
	assign diff = sum_h_nxt - sum_l_nxt;

	// polarity first, then the offset
	always_comb begin
		if (i_polarity) begin
			err_nxt = -diff + i_err_offset;
		end else begin
			err_nxt = diff + i_err_offset;
		end
	end

	// sums restart every period
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			sum_h <= '0;
			sum_l <= '0;
		end else if (i_period_stb) begin
			sum_h <= '0;
			sum_l <= '0;
		end else begin
			sum_h <= sum_h_nxt;
			sum_l <= sum_l_nxt;
		end
	end

	// error register, one cycle behind period_stb
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_err     <= '0;
			o_err_stb <= 1'b0;
		end else begin
			o_err_stb <= i_period_stb;
			if (i_period_stb) begin
				o_err <= err_nxt;  // held until the next period closes
			end
		end
	end

endmodule

/* hw/fog_feedback.sv */
`timescale 1ns/1ps

module fog_feedback (
	input  logic           i_clk,
	input  logic           i_reset,
	input  fog_pkg::word_t i_err,        // per-period demodulated error
	input  logic           i_err_stb,    // i_err is new this cycle
	input  logic           i_fb_on,      // 0 runs the ramp open loop
	input  fog_pkg::gain_t i_gain_sel,   // loop gain as 2^-n
	input  fog_pkg::word_t i_const_step, // step used with feedback off
	input  fog_pkg::word_t i_mod_value,  // bias modulation level
	output fog_pkg::word_t o_step,
	output fog_pkg::word_t o_ramp,
	output fog_pkg::dac_t  o_dac
);
	import fog_pkg::*;

	word_t err_scaled;  // error after gain shift
	word_t step_nxt;
	dac_t  dac_nxt;

	// arithmetic shift keeps the sign of the error
	assign err_scaled = i_err >>> i_gain_sel;

	always_comb begin
		if (i_fb_on) begin
			step_nxt = o_step + err_scaled;  // integrate
		end else begin
			step_nxt = i_const_step;
		end
	end

	// both wrap modulo 2^16, the DAC sees only the low word
	assign dac_nxt = o_ramp[DAC_W-1:0] + i_mod_value[DAC_W-1:0];

	// step integrator and phase ramp move together once per period
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_step <= '0;
			o_ramp <= '0;
		end else if (i_err_stb) begin
			o_step <= step_nxt;
			o_ramp <= o_ramp + o_step;  // old step, wraps at 32 bits
		end
	end

	// DAC word refreshed every clock so the modulation edges pass through
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_dac <= '0;
		end else begin
			o_dac <= dac_nxt;  // one cycle behind mod_value
		end
	end

endmodule

/* hw/fog_mod_gen.sv */
`timescale 1ns/1ps

module fog_mod_gen (
	input  logic                i_clk,
	input  logic                i_reset,
	input  fog_pkg::cnt_t       i_freq_cnt,   // half period in clocks
	input  fog_pkg::word_t      i_amp_h,      // level of the high half
	input  fog_pkg::word_t      i_amp_l,      // level of the low half
	output fog_pkg::mod_phase_t o_phase,
	output fog_pkg::word_t      o_mod_value,
	output logic                o_half_stb,   // last cycle of either half
	output logic                o_period_stb, // last cycle of the low half
	output fog_pkg::cnt_t       o_half_idx    // position inside current half
);
	import fog_pkg::*;

	cnt_t half_len;  // clamped half period
	logic half_end;

	// anything below MIN_HALF is stretched
	assign half_len = (i_freq_cnt < cnt_t'(MIN_HALF)) ? cnt_t'(MIN_HALF) : i_freq_cnt;

	// >= so a shrinking setting still ends the half
	assign half_end = (o_half_idx >= half_len - cnt_t'(1));

	// in-half counter and phase FSM
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_half_idx <= '0;
			o_phase    <= MOD_HIGH;  // waveform always starts high
		end else if (half_end) begin
			o_half_idx <= '0;
			case (o_phase)
				MOD_HIGH: o_phase <= MOD_LOW;
				MOD_LOW:  o_phase <= MOD_HIGH;
				default:  o_phase <= MOD_HIGH;
			endcase
		end else begin
			o_half_idx <= o_half_idx + cnt_t'(1);
		end
	end

	assign o_half_stb   = half_end;
	assign o_period_stb = half_end && (o_phase == MOD_LOW);  // full period done

	// level follows the phase directly, no extra stage
	assign o_mod_value = (o_phase == MOD_HIGH) ? i_amp_h : i_amp_l;

endmodule

/* hw/fog_pkg.sv */
package fog_pkg;

	// converter and loop widths
	localparam int ADC_W  = 14;  // signed samples from the front-end ADC
	localparam int DAC_W  = 16;  // phase modulator DAC word
	localparam int WORD_W = 32;  // loop arithmetic and counter width
	localparam int GAIN_W = 5;   // shift range 0..31

	// clocks per timer increment, as on the board
	localparam int TIMER_TICKS = 10000;

	// a half period shorter than this leaves no room for the phase toggle
	localparam int MIN_HALF = 2;

	// one raw ADC sample
	typedef logic signed [ADC_W-1:0] adc_t;

	// DAC output word, wraps freely
	typedef logic [DAC_W-1:0] dac_t;

	// error, step, ramp, amplitudes, offsets
	typedef logic signed [WORD_W-1:0] word_t;

	// half period, settling wait, sync interval
	typedef logic [WORD_W-1:0] cnt_t;

	// feedback gain as a right shift
	typedef logic [GAIN_W-1:0] gain_t;

	// bias modulation state
	typedef enum logic {
		MOD_HIGH = 1'b0,  // first half after reset
		MOD_LOW  = 1'b1   // second half, period ends here
	} mod_phase_t;

endpackage

/* hw/fog_timebase.sv */
`timescale 1ns/1ps

module fog_timebase #(
	parameter int ticks = fog_pkg::TIMER_TICKS  // clocks per timer count
) (
	input  logic           i_clk,
	input  logic           i_reset,
	input  fog_pkg::cnt_t  i_sync_count,  // sync pulse interval in clocks
	input  logic           i_timer_rst,   // holds the timer at zero
	output logic           o_sync,
	output fog_pkg::word_t o_timer
);
	import fog_pkg::*;

	cnt_t sync_cnt;  // clocks since the last pulse
	cnt_t tick_cnt;  // prescaler for the timer
	logic sync_hit;
	logic tick_hit;

	// 0 as interval never matches, so no pulses
	assign sync_hit = (sync_cnt == i_sync_count - cnt_t'(1));
	assign tick_hit = (tick_cnt == cnt_t'(ticks - 1));

	// sync interval counter, pulse lasts one clock
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			sync_cnt <= '0;
			o_sync   <= 1'b0;
		end else begin
			o_sync   <= sync_hit;
			sync_cnt <= sync_hit ? '0 : sync_cnt + cnt_t'(1);
		end
	end

	// free-running timer, cleared by software
	always_ff @(posedge i_clk) begin
		if (i_reset || i_timer_rst) begin
			tick_cnt <= '0;
			o_timer  <= '0;
		end else if (tick_hit) begin
			tick_cnt <= '0;
			o_timer  <= o_timer + word_t'(1);
		end else begin
			tick_cnt <= tick_cnt + cnt_t'(1);
		end
	end

endmodule

/* hw/iris_top.sv */
`timescale 1ns/1ps

module iris_top #(
	parameter int ticks = fog_pkg::TIMER_TICKS  // passed to the timer prescaler
) (
	input  logic           i_clk,
	input  logic           i_reset,
	input  fog_pkg::adc_t  i_adc,
	input  fog_pkg::cnt_t  i_freq_cnt,
	input  fog_pkg::cnt_t  i_wait_cnt,
	input  fog_pkg::cnt_t  i_sync_count,
	input  fog_pkg::word_t i_amp_h,
	input  fog_pkg::word_t i_amp_l,
	input  fog_pkg::word_t i_err_offset,
	input  fog_pkg::word_t i_const_step,
	input  logic           i_polarity,
	input  logic           i_fb_on,
	input  logic           i_timer_rst,
	input  fog_pkg::gain_t i_gain_sel,
	output fog_pkg::dac_t  o_dac,
	output fog_pkg::word_t o_err,
	output fog_pkg::word_t o_step,
	output fog_pkg::word_t o_phase_ramp,
	output fog_pkg::word_t o_timer,
	output logic           o_err_stb,
	output logic           o_sync
);
	import fog_pkg::*;

	mod_phase_t mod_phase;
	word_t      mod_value;
	logic       period_stb;
	cnt_t       half_idx;  // shared with the demodulator wait gate

	fog_mod_gen u_mod_gen (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_freq_cnt   (i_freq_cnt),
		.i_amp_h      (i_amp_h),
		.i_amp_l      (i_amp_l),
		.o_phase      (mod_phase),
		.o_mod_value  (mod_value),
		.o_half_stb   (),            // demod works off half_idx instead
		.o_period_stb (period_stb),
		.o_half_idx   (half_idx)
	);

	fog_err_demod u_err_demod (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_adc        (i_adc),
		.i_phase      (mod_phase),
		.i_half_idx   (half_idx),
		.i_period_stb (period_stb),
		.i_wait_cnt   (i_wait_cnt),
		.i_polarity   (i_polarity),
		.i_err_offset (i_err_offset),
		.o_err        (o_err),
		.o_err_stb    (o_err_stb)
	);

	// error also feeds the step integrator
	fog_feedback u_feedback (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_err        (o_err),
		.i_err_stb    (o_err_stb),
		.i_fb_on      (i_fb_on),
		.i_gain_sel   (i_gain_sel),
		.i_const_step (i_const_step),
		.i_mod_value  (mod_value),
		.o_step       (o_step),
		.o_ramp       (o_phase_ramp),
		.o_dac        (o_dac)
	);

	fog_timebase #(
		.ticks (ticks)
	) u_timebase (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_sync_count (i_sync_count),
		.i_timer_rst  (i_timer_rst),
		.o_sync       (o_sync),
		.o_timer      (o_timer)
	);

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the iris testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_iris -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_iris)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
	exit 0
fi
exit 1

/* verif/tb_iris.sv */
`timescale 1ns/1ps

module tb_iris;
	import fog_pkg::*;

	localparam int TB_TICKS   = 8;     // short timer prescaler for simulation
	localparam int MAX_CYCLES = 4000;  // six tests of well under 600 cycles, plus margin

	logic  i_clk = 1'b0;
	logic  i_reset;
	adc_t  i_adc;
	cnt_t  i_freq_cnt;
	cnt_t  i_wait_cnt;
	cnt_t  i_sync_count;
	word_t i_amp_h;
	word_t i_amp_l;
	word_t i_err_offset;
	word_t i_const_step;
	logic  i_polarity;
	logic  i_fb_on;
	logic  i_timer_rst;
	gain_t i_gain_sel;
	dac_t  o_dac;
	word_t o_err;
	word_t o_step;
	word_t o_phase_ramp;
	word_t o_timer;
	logic  o_err_stb;
	logic  o_sync;

	logic adc_rand;     // fresh random sample every cycle
	int   n_cycles = 0;
	int   n_checks = 0;
	int   n_errors = 0;
	int   n_stb = 0;    // err strobes seen
	int   n_sync = 0;   // sync pulses seen

	// reference state
	cnt_t       m_idx;
	mod_phase_t m_phase;
	word_t      m_sum_h;
	word_t      m_sum_l;
	word_t      m_err;
	logic       m_err_stb;
	word_t      m_step;
	word_t      m_ramp;
	dac_t       m_dac;
	cnt_t       m_cyc;  // edges since reset
	cnt_t       m_run;  // edges since the last timer clear

	iris_top #(.ticks(TB_TICKS)) i_dut (.*);

	always #10 i_clk = ~i_clk;

	// behavioral model of the channel and timebase
	always @(posedge i_clk) begin : ref_model
		cnt_t  hl;
		word_t smp;
		word_t nh;
		word_t nl;
		word_t diff;
		logic  pend;
		if (i_reset) begin
			m_idx <= '0;
			m_phase <= MOD_HIGH;
			m_sum_h <= '0;
			m_sum_l <= '0;
			m_err <= '0;
			m_err_stb <= 1'b0;
			m_step <= '0;
			m_ramp <= '0;
			m_dac <= '0;
			m_cyc <= '0;
			m_run <= '0;
		end else begin
			hl = (i_freq_cnt < 2) ? 32'd2 : i_freq_cnt;
			smp = {{18{i_adc[13]}}, i_adc};  // 14 to 32 bit sign extension
			nh = m_sum_h;
			nl = m_sum_l;
			if (m_idx >= i_wait_cnt) begin
				if (m_phase == MOD_LOW) nl = nl + smp;
				else nh = nh + smp;
			end
			pend = (m_idx == hl - 1) && (m_phase == MOD_LOW);
			diff = nh - nl;
			m_idx <= (m_idx == hl - 1) ? '0 : m_idx + 1;
			if (m_idx == hl - 1) m_phase <= (m_phase == MOD_HIGH) ? MOD_LOW : MOD_HIGH;
			m_sum_h <= pend ? '0 : nh;
			m_sum_l <= pend ? '0 : nl;
			m_err_stb <= pend;
			if (pend) m_err <= (i_polarity ? -diff : diff) + i_err_offset;
			if (m_err_stb) begin
				m_step <= i_fb_on ? m_step + (m_err >>> i_gain_sel) : i_const_step;
				m_ramp <= m_ramp + m_step;  // wraps at 32 bits
			end
			m_dac <= m_ramp[15:0] + ((m_phase == MOD_LOW) ? i_amp_l[15:0] : i_amp_h[15:0]);
			m_cyc <= m_cyc + 1;
			m_run <= i_timer_rst ? '0 : m_run + 1;
		end
	end

	// compare on the falling edge, outputs settled
	always @(negedge i_clk) begin
		if (!i_reset) begin
			n_checks++;
			assert (o_dac == m_dac) else begin
				n_errors++;
				$display("FAILED o_dac: got %h expected %h", o_dac, m_dac);
			end
			assert (o_err_stb == m_err_stb) else begin
				n_errors++;
				$display("FAILED o_err_stb: got %h expected %h", o_err_stb, m_err_stb);
			end
			assert (o_err == m_err) else begin
				n_errors++;
				$display("FAILED o_err: got %h expected %h", o_err, m_err);
			end
			assert (o_step == m_step) else begin
				n_errors++;
				$display("FAILED o_step: got %h expected %h", o_step, m_step);
			end
			assert (o_phase_ramp == m_ramp) else begin
				n_errors++;
				$display("FAILED o_phase_ramp: got %h expected %h", o_phase_ramp, m_ramp);
			end
			assert (o_sync == (m_cyc != 0 && m_cyc % i_sync_count == 0)) else begin
				n_errors++;
				$display("FAILED o_sync: got %h expected %h", o_sync,
					(m_cyc != 0 && m_cyc % i_sync_count == 0));
			end
			assert (o_timer == word_t'(m_run / TB_TICKS)) else begin
				n_errors++;
				$display("FAILED o_timer: got %h expected %h", o_timer, m_run / TB_TICKS);
			end
			if (o_err_stb) n_stb++;
			if (o_sync) n_sync++;
		end
	end

	// hang guard
	always @(posedge i_clk) begin
		n_cycles <= n_cycles + 1;
		if (n_cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, expected strobes never arrived", n_cycles);
			$display("Something failed");
			$finish;
		end
	end

	task automatic step_cycle();
		@(posedge i_clk);
		#1;
		if (adc_rand) i_adc = adc_t'($urandom);
	endtask

	// reset goes high, settings are loaded while it is held
	task automatic begin_test();
		i_reset = 1'b1;
		adc_rand = 1'b0;
		i_adc = '0;
		i_freq_cnt = 32'd5;
		i_wait_cnt = '0;
		i_sync_count = 32'd13;
		i_amp_h = 32'h1234_5678;
		i_amp_l = -32'sd300;
		i_err_offset = '0;
		i_const_step = '0;
		i_polarity = 1'b0;
		i_fb_on = 1'b0;
		i_timer_rst = 1'b0;
		i_gain_sel = '0;
		step_cycle();
	endtask

	task automatic run_test(input int n);
		int target;
		step_cycle();  // second reset cycle
		i_reset = 1'b0;
		target = n_stb + n;
		while (n_stb < target) step_cycle();
	endtask

	task automatic wait_syncs(input int n);
		int target;
		target = n_sync + n;
		while (n_sync < target) step_cycle();
	endtask

	initial begin
		void'($urandom(17074));
		i_reset = 1'b1;
		begin_test();
		// 1 plain square wave on the dac
		run_test(6);
		// 2 constant adc, only the offset is left
		begin_test();
		i_freq_cnt = 32'd7;
		i_adc = 14'sd100;
		i_err_offset = 32'h55;
		run_test(6);
		assert (o_err == 32'h55) else begin
			n_errors++;
			$display("FAILED o_err: got %h expected %h", o_err, 32'h55);
		end
		// 3 random samples with settling wait, both polarities
		begin_test();
		i_freq_cnt = 32'd9;
		i_wait_cnt = 32'd3;
		adc_rand = 1'b1;
		run_test(6);
		begin_test();
		i_freq_cnt = 32'd9;
		i_wait_cnt = 32'd3;
		i_polarity = 1'b1;
		adc_rand = 1'b1;
		run_test(6);
		// 4 open loop ramp, wraps after a few periods
		begin_test();
		i_freq_cnt = 32'd6;
		i_amp_h = 32'sd100;
		i_amp_l = -32'sd100;
		i_const_step = 32'h3000_0000;
		run_test(1);
		assert (o_step == 32'h3000_0000) else begin
			n_errors++;
			$display("FAILED o_step: got %h expected %h", o_step, 32'h3000_0000);
		end
		run_test(7);
		// 5 closed loop, gain 2^-4
		begin_test();
		i_freq_cnt = 32'd8;
		i_wait_cnt = 32'd2;
		i_err_offset = -32'sd1000;
		i_fb_on = 1'b1;
		i_gain_sel = 5'd4;
		adc_rand = 1'b1;
		run_test(8);
		// 6 sync pulses and timer clear
		begin_test();
		run_test(0);
		wait_syncs(3);
		i_timer_rst = 1'b1;
		repeat (20) begin
			step_cycle();
			assert (o_timer == '0) else begin
				n_errors++;
				$display("FAILED o_timer: got %h expected %h", o_timer, 32'h0);
			end
		end
		i_timer_rst = 1'b0;
		wait_syncs(4);
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
